// ==== dmm_top.f ====
+incdir+hdl
+incdir+tb
hdl/dmm_pkg.sv
hdl/spi_reg_bank.sv
hdl/seq_acq.sv
hdl/adc_mock.sv
hdl/pin_mux.sv
hdl/dmm_top.sv
tb/dmm_tb.sv

// ==== Bender.yml ====
package:
  name: dmm_fpga

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dmm_pkg.sv
      - hdl/spi_reg_bank.sv
      - hdl/seq_acq.sv
      - hdl/adc_mock.sv
      - hdl/pin_mux.sv
      - hdl/dmm_top.sv
  - target: test
    include_dirs:
      - hdl
      - tb
    files:
      - tb/dmm_tb.sv

// ==== tb/dmm_tb_check.svh ====
//////////////////////////////////////////////////////////////////////
// reference model of the register bank

logic [`DMM_REG_W-1:0]   model_regs [`DMM_REG_FIRST:`DMM_REG_LAST];
logic [`DMM_SEQ_N_W-1:0] model_idx_last;   // last entry that got a meas pulse

int word_errs  = 0;
int pin_errs   = 0;
int route_errs = 0;
int other_errs = 0;

function automatic logic [`DMM_REG_W-1:0] model_status();
  return {8'h00,
          1'b0, model_regs[REG_SA_SEQ_N][`DMM_SEQ_N_W-1:0], 1'b0, model_idx_last,
          model_regs[REG_SPI_MUX][3:0], hw_flags_i,
          `DMM_STATUS_MAGIC};
endfunction

function automatic logic [`DMM_REG_W-1:0] model_read(input logic [`DMM_ADDR_W-1:0] addr);
  if (addr == REG_STATUS) return model_status();   // live word
  if (addr >= `DMM_REG_FIRST && addr <= `DMM_REG_LAST) return model_regs[addr];
  return '0;   // outside the map
endfunction

function automatic void model_write(input logic [`DMM_ADDR_W-1:0] addr,
                                    input logic [`DMM_REG_W-1:0]  data);
  if (addr >= `DMM_REG_FIRST && addr <= `DMM_REG_LAST && addr != REG_STATUS)
    model_regs[addr] = data;   // status and unmapped writes vanish
endfunction

// routed lines, msb first: glb_clk glb_mosi strobe oe dac_ss iso_cs iso_cs2
function automatic logic [6:0] expected_route(input logic [3:0] mux,
                                              input logic sck, sdi, cs2, oe);
  logic [6:0] r;
  r[6] = (mux == 4'd0) ? 1'b1 : sck;   // parked hi
  r[5] = (mux == 4'd0) ? 1'b1 : sdi;
  r[4] = (mux == 4'd1) ? ~cs2 : 1'b0;
  r[3] = oe;
  r[2] = (mux == 4'd2) ? cs2 : 1'b1;
  r[1] = (mux == 4'd4) ? cs2 : 1'b1;
  r[0] = (mux == 4'd8) ? cs2 : 1'b1;
  return r;
endfunction

//////////////////////////////////////////////////////////////////////
// compare tasks

task automatic check_word(input string name, input logic [`DMM_REG_W-1:0] exp,
                          input logic [`DMM_REG_W-1:0] got);
  if (got !== exp) begin
    word_errs++;
    $display("mismatch %s: expected %h, got %h", name, exp, got);
  end
endtask

// mask picks the fields that the rule fixes
task automatic check_pins(input string name, input out_vec_t exp, input out_vec_t got,
                          input out_vec_t mask);
  if ((got & mask) !== (exp & mask)) begin
    pin_errs++;
    $display("mismatch %s: expected %h, got %h (mask %h)", name, exp, got, mask);
  end
endtask

task automatic check_route(input string name, input logic [6:0] exp, input logic [6:0] got);
  if (got !== exp) begin
    route_errs++;
    $display("mismatch %s: expected %h, got %h", name, exp, got);
  end
endtask

// ==== tb/dmm_tb.sv ====
`include "dmm_consts.svh"

module dmm_tb import dmm_pkg::*; ();

  localparam int N_FRAMES        = 60;
  localparam int N_SAMPLES       = 12;
  localparam int MAX_PC          = 7;    // small precharge and aperture
  localparam int MAX_AP          = 7;
  localparam int MAX_SAMPLE_CLKS = MAX_PC + MAX_AP + 4;
  localparam int LIMIT = N_FRAMES * `DMM_FRAME_BITS * 8 + N_SAMPLES * MAX_SAMPLE_CLKS + 2000;

  logic clk, reset_i, sck_i, ss_i, sdi_i, cs2_i, sa_trig_i;
  logic [3:0] hw_flags_i;
  logic sdo_o, spi_glb_clk_o, spi_glb_mosi_o, spi_4094_strobe_o, spi_4094_oe_o;
  logic spi_dac_ss_o, spi_iso_dac_cs_o, spi_iso_dac_cs2_o;
  logic [3:0] leds_o, azmux_o, adc_refmux_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o;
  logic adc_cmpr_latch_o, spi_interrupt_o, meas_complete_o, adc_reset_n_o;

  out_vec_t   pins_seen;   // pin ports packed back up
  logic [6:0] routed;
  logic [3:0] mux_list [6] = '{4'd0, 4'd1, 4'd2, 4'd4, 4'd8, 4'd3};
  int unsigned seed_ret;
  int cycles = 0;

  assign pins_seen = {adc_reset_n_o, meas_complete_o, spi_interrupt_o, adc_cmpr_latch_o,
                      adc_refmux_o, azmux_o, pc_sw_o, monitor_o, leds_o};
  assign routed = {spi_glb_clk_o, spi_glb_mosi_o, spi_4094_strobe_o, spi_4094_oe_o,
                   spi_dac_ss_o, spi_iso_dac_cs_o, spi_iso_dac_cs2_o};

  `include "dmm_tb_check.svh"

  dmm_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // hard stop, frames plus samples plus slack
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // spi master, sck at clk/8, mode 0

  task automatic spi_frame(input logic [`DMM_ADDR_W-1:0] addr, input logic [`DMM_REG_W-1:0] data,
                           output logic [`DMM_REG_W-1:0] rd);
    logic [`DMM_FRAME_BITS-1:0] frame;
    frame = {addr, data};
    rd = '0;
    @(posedge clk);
    ss_i <= 1'b0;
    for (int k = 0; k < `DMM_FRAME_BITS; k++) begin
      @(posedge clk);
      sck_i <= 1'b0;
      sdi_i <= frame[`DMM_FRAME_BITS-1-k];
      repeat (3) @(posedge clk);
      @(negedge clk);   // sdo settled late in the low half
      if (k >= `DMM_ADDR_W) rd = {rd[`DMM_REG_W-2:0], sdo_o};
      @(posedge clk);
      sck_i <= 1'b1;
      repeat (3) @(posedge clk);
    end
    @(posedge clk);
    sck_i <= 1'b0;
    repeat (4) @(posedge clk);
    ss_i <= 1'b1;
    repeat (8) @(posedge clk);   // write lands a few clks after ss rises
  endtask

  task automatic write_reg(input logic [`DMM_ADDR_W-1:0] addr, input logic [`DMM_REG_W-1:0] data);
    logic [`DMM_REG_W-1:0] rd;
    spi_frame(addr, data, rd);
    check_word($sformatf("sdo_o (addr %h, before write)", addr), model_read(addr), rd);
    model_write(addr, data);
  endtask

  // writes the expected value back, so the bank stays unchanged
  task automatic read_check(input logic [`DMM_ADDR_W-1:0] addr);
    logic [`DMM_REG_W-1:0] exp, rd;
    exp = model_read(addr);
    spi_frame(addr, exp, rd);
    check_word($sformatf("sdo_o (addr %h)", addr), exp, rd);
  endtask

  task automatic wait_meas(output bit seen);
    seen = 1'b0;
    for (int c = 0; c < 4 * MAX_SAMPLE_CLKS && !seen; c++) begin
      @(negedge clk);
      seen = meas_complete_o;
    end
    if (!seen) begin
      other_errs++;
      $display("no meas_complete pulse within %0d cycles", 4 * MAX_SAMPLE_CLKS);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin : stimulus
    logic [`DMM_REG_W-1:0] d;
    out_vec_t  exp_pins, mask;
    sa_entry_t entry;
    int        seq_n;
    bit        seen;
    logic [1:0] idx;

    seed_ret   = $urandom(55);
    reset_i    = 1'b1;
    sck_i      = 1'b0;
    ss_i       = 1'b1;   // bank deselected
    sdi_i      = 1'b0;
    cs2_i      = 1'b1;
    sa_trig_i  = 1'b0;
    hw_flags_i = 4'($urandom_range(0, 15));
    for (int a = `DMM_REG_FIRST; a <= `DMM_REG_LAST; a++) model_regs[a] = '0;
    model_idx_last = '0;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;

    // reset values
    @(negedge clk);
    check_pins("pins_o after reset", '0, pins_seen, '1);
    check_route("spi routing after reset", expected_route(4'd0, sck_i, sdi_i, cs2_i, 1'b0),
                routed);
    read_check(REG_STATUS);

    // register round trip, two passes then illegal writes
    repeat (2) begin
      for (int a = `DMM_REG_FIRST; a <= `DMM_REG_LAST; a++)
        if (a != REG_STATUS) write_reg(a, $urandom);
    end
    write_reg(REG_STATUS, $urandom);   // read only
    write_reg(8'd0, $urandom);
    write_reg(8'($urandom_range(13, 255)), $urandom);
    for (int a = 0; a <= `DMM_REG_LAST + 1; a++) read_check(a);

    // direct mode
    write_reg(REG_MODE, MODE_DIRECT);
    repeat (4) begin
      d = $urandom;
      write_reg(REG_DIRECT, d);
      @(negedge clk);
      check_pins("pins_o direct", out_vec_t'(d[`DMM_OUT_W-1:0]), pins_seen, '1);
    end

    // spi routing
    foreach (mux_list[m]) begin
      write_reg(REG_SPI_MUX, {28'h0, mux_list[m]});
      repeat (4) begin
        @(posedge clk);
        cs2_i <= 1'($urandom_range(0, 1));
        sck_i <= 1'($urandom_range(0, 1));   // ss hi, bank ignores these
        sdi_i <= 1'($urandom_range(0, 1));
        @(negedge clk);
        check_route($sformatf("spi routing (spi_mux %h)", mux_list[m]),
                    expected_route(mux_list[m], sck_i, sdi_i, cs2_i, model_regs[REG_4094][0]),
                    routed);
      end
    end
    @(posedge clk);
    sck_i <= 1'b0;
    sdi_i <= 1'b0;
    cs2_i <= 1'b1;

    //////////////////////////////////////////////////////////////////////
    // sequence acquisition with mock adc

    seq_n = $urandom_range(1, `DMM_SEQ_MAX);
    write_reg(REG_SA_SEQ_N, seq_n);
    for (int i = 0; i < `DMM_SEQ_MAX; i++) write_reg(REG_SA_SEQ0 + i, $urandom);
    write_reg(REG_SA_PRECHARGE, $urandom_range(0, MAX_PC));
    write_reg(REG_ADC_APERTURE, $urandom_range(0, MAX_AP));
    write_reg(REG_MODE, MODE_SA_MOCK);
    mask = '1;
    mask.monitor = '0;   // scope view only
    @(posedge clk);
    sa_trig_i <= 1'b1;
    for (int s = 0; s < N_SAMPLES; s++) begin
      idx = 2'(s % seq_n);   // cyclic from entry 0
      wait_meas(seen);
      if (!seen) break;
      entry = sa_entry_t'(model_regs[REG_SA_SEQ0 + idx][`DMM_SEQ_W-1:0]);
      exp_pins = '0;
      exp_pins.adc_reset_n   = 1'b1;   // adc_start still up
      exp_pins.meas_complete = 1'b1;
      exp_pins.spi_interrupt = 1'b1;
      exp_pins.azmux = entry.azmux;
      exp_pins.pc_sw = entry.pc_sw;
      exp_pins.leds  = 4'b0001 << idx;
      check_pins($sformatf("pins_o sample %0d", s), exp_pins, pins_seen, mask);
      model_idx_last = {1'b0, idx};
    end
    @(posedge clk);
    sa_trig_i <= 1'b0;
    read_check(REG_STATUS);   // sample_idx_last of the final pulse

    $display("errors: word %0d, pins %0d, route %0d, other %0d",
             word_errs, pin_errs, route_errs, other_errs);
    if (word_errs + pin_errs + route_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== hdl/dmm_top.sv ====
module dmm_top import dmm_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,

  // mcu spi
  input  logic       sck_i,
  input  logic       ss_i,
  input  logic       sdi_i,
  input  logic       cs2_i,
  output logic       sdo_o,

  input  logic       sa_trig_i,
  input  logic [3:0] hw_flags_i,

  // routed spi
  output logic       spi_glb_clk_o,
  output logic       spi_glb_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_4094_oe_o,
  output logic       spi_dac_ss_o,
  output logic       spi_iso_dac_cs_o,
  output logic       spi_iso_dac_cs2_o,

  // front end pins
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,       // u410
  output logic [3:0] adc_refmux_o,
  output logic       adc_cmpr_latch_o,
  output logic       spi_interrupt_o,
  output logic       meas_complete_o,
  output logic       adc_reset_n_o
);

  reg_cfg_t       cfg;
  out_vec_t       sa_pins, pins;
  logic [2:0]     sample_idx_last;
  logic           adc_start, meas_valid;

  spi_reg_bank u_regs (
    .clk               (clk),
    .reset_i           (reset_i),
    .sck_i             (sck_i),
    .ss_i              (ss_i),
    .sdi_i             (sdi_i),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sample_idx_last),
    .sdo_o             (sdo_o),
    .cfg_o             (cfg)
  );

  seq_acq u_seq (
    .clk               (clk),
    .reset_i           (reset_i),
    .sa_trig_i         (sa_trig_i),
    .sa_cfg_i          (cfg.sa),
    .meas_valid_i      (meas_valid),    // from mock adc
    .adc_start_o       (adc_start),
    .pins_o            (sa_pins),
    .sample_idx_last_o (sample_idx_last)
  );

  adc_mock u_adc (
    .clk          (clk),
    .reset_i      (reset_i),
    .adc_start_i  (adc_start),
    .aperture_i   (cfg.aperture),
    .meas_valid_o (meas_valid)
  );

  pin_mux u_mux (
    .clk               (clk),
    .cfg_i             (cfg),
    .sa_pins_i         (sa_pins),
    .meas_valid_i      (meas_valid),
    .sck_i             (sck_i),
    .sdi_i             (sdi_i),
    .cs2_i             (cs2_i),
    .spi_glb_clk_o     (spi_glb_clk_o),
    .spi_glb_mosi_o    (spi_glb_mosi_o),
    .spi_4094_strobe_o (spi_4094_strobe_o),
    .spi_4094_oe_o     (spi_4094_oe_o),
    .spi_dac_ss_o      (spi_dac_ss_o),
    .spi_iso_dac_cs_o  (spi_iso_dac_cs_o),
    .spi_iso_dac_cs2_o (spi_iso_dac_cs2_o),
    .pins_o            (pins)
  );

  // pin vector onto the board nets
  assign adc_reset_n_o    = pins.adc_reset_n;
  assign meas_complete_o  = pins.meas_complete;
  assign spi_interrupt_o  = pins.spi_interrupt;
  assign adc_cmpr_latch_o = pins.cmpr_latch;
  assign adc_refmux_o     = pins.adc_refmux;
  assign azmux_o          = pins.azmux;
  assign pc_sw_o          = pins.pc_sw;
  assign monitor_o        = pins.monitor;
  assign leds_o           = pins.leds;

endmodule

// ==== hdl/pin_mux.sv ====
module pin_mux import dmm_pkg::*; (
  input  logic     clk,            // assertion sampling only
  input  reg_cfg_t cfg_i,
  input  out_vec_t sa_pins_i,
  input  logic     meas_valid_i,
  input  logic     sck_i,
  input  logic     sdi_i,
  input  logic     cs2_i,
  output logic     spi_glb_clk_o,
  output logic     spi_glb_mosi_o,
  output logic     spi_4094_strobe_o,
  output logic     spi_4094_oe_o,
  output logic     spi_dac_ss_o,
  output logic     spi_iso_dac_cs_o,
  output logic     spi_iso_dac_cs2_o,
  output out_vec_t pins_o
);

  //////////////////////////////////////////////////////////////////////
  // spi routing

  assign spi_glb_clk_o     = (cfg_i.spi_mux == 4'd0) ? 1'b1 : sck_i;    // park hi
  assign spi_glb_mosi_o    = (cfg_i.spi_mux == 4'd0) ? 1'b1 : sdi_i;

  assign spi_4094_strobe_o = (cfg_i.spi_mux == 4'd1) ? ~cs2_i : 1'b0;   // active hi
  assign spi_dac_ss_o      = (cfg_i.spi_mux == 4'd2) ? cs2_i : 1'b1;    // active lo
  assign spi_iso_dac_cs_o  = (cfg_i.spi_mux == 4'd4) ? cs2_i : 1'b1;
  assign spi_iso_dac_cs2_o = (cfg_i.spi_mux == 4'd8) ? cs2_i : 1'b1;

  assign spi_4094_oe_o     = cfg_i.oe_4094;

  //////////////////////////////////////////////////////////////////////
  // output function select

  out_vec_t sa_merged;

  always_comb begin
    sa_merged               = sa_pins_i;
    sa_merged.meas_complete = meas_valid_i;   // mcu sees the sample on both lines
    sa_merged.spi_interrupt = meas_valid_i;
    case (cfg_i.mode)
      MODE_DIRECT:  pins_o = cfg_i.direct;    // full pin control, board bring-up
      MODE_SA_MOCK: pins_o = sa_merged;
      default:      pins_o = '0;
    endcase
  end

  // two peripherals never share the bus
  a_one_cs: assert property (@(posedge clk)
    $onehot0({spi_4094_strobe_o, ~spi_dac_ss_o, ~spi_iso_dac_cs_o, ~spi_iso_dac_cs2_o}));

endmodule

// ==== hdl/adc_mock.sv ====
`include "dmm_consts.svh"

module adc_mock (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  adc_start_i,
  input  logic [`DMM_CNT_W-1:0] aperture_i,
  output logic                  meas_valid_o
);

  logic [`DMM_CNT_W-1:0] cnt_q;    // clks since adc_start rose
  logic                  done_q;   // answered, wait for start to drop

  always_ff @(posedge clk) begin
    if (reset_i) begin
      cnt_q        <= '0;
      done_q       <= 1'b0;
      meas_valid_o <= 1'b0;
    end else begin
      meas_valid_o <= 1'b0;   // single clk pulse
      if (!adc_start_i) begin
        cnt_q  <= '0;
        done_q <= 1'b0;
      end else if (!done_q) begin
        if (cnt_q == aperture_i) begin   // valid lands aperture+1 after the rise
          meas_valid_o <= 1'b1;
          done_q       <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  a_valid_pulse: assert property (@(posedge clk) disable iff (reset_i)
    meas_valid_o |=> !meas_valid_o);

endmodule

// ==== hdl/seq_acq.sv ====
`include "dmm_consts.svh"

module seq_acq import dmm_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    sa_trig_i,
  input  sa_cfg_t                 sa_cfg_i,
  input  logic                    meas_valid_i,
  output logic                    adc_start_o,
  output out_vec_t                pins_o,
  output logic [`DMM_SEQ_N_W-1:0] sample_idx_last_o
);

  sa_state_e              state_q;
  logic [`DMM_IDX_W-1:0]  idx_q;        // current entry
  logic [`DMM_IDX_W-1:0]  idx_next;
  logic [`DMM_CNT_W-1:0]  pc_cnt_q;     // precharge counter
  sa_entry_t              entry;

  assign entry = sa_cfg_i.seq[idx_q];

  // wrap on seq_n, a zero seq_n behaves as one entry
  assign idx_next = ({1'b0, idx_q} + 1'b1 >= sa_cfg_i.seq_n) ? '0 : idx_q + 1'b1;

  assign adc_start_o = (state_q == SA_MEASURE);   // held until the adc answers

  //////////////////////////////////////////////////////////////////////
  // sequence FSM

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q           <= SA_IDLE;
      idx_q             <= '0;
      pc_cnt_q          <= '0;
      sample_idx_last_o <= '0;
    end else if (!sa_trig_i) begin   // trigger lo parks at entry 0
      state_q  <= SA_IDLE;
      idx_q    <= '0;
      pc_cnt_q <= '0;
    end else begin
      case (state_q)
        SA_IDLE: begin
          state_q  <= SA_SETTLE;
          pc_cnt_q <= '0;
        end
        SA_SETTLE: begin
          if (pc_cnt_q == sa_cfg_i.precharge) state_q <= SA_MEASURE;   // precharge+1 clks
          else pc_cnt_q <= pc_cnt_q + 1'b1;
        end
        SA_MEASURE: begin
          if (meas_valid_i) begin
            sample_idx_last_o <= {1'b0, idx_q};   // entry just measured
            idx_q             <= idx_next;
            pc_cnt_q          <= '0;
            state_q           <= SA_SETTLE;
          end
        end
        default: state_q <= SA_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pin vector

  always_comb begin
    pins_o             = '0;
    pins_o.adc_reset_n = adc_start_o;   // meas flags get merged downstream
    if (state_q != SA_IDLE) begin
      pins_o.azmux = entry.azmux;
      pins_o.pc_sw = entry.pc_sw;
    end
    // scope view, hi pc_sw bit marks the ch1 precharge
    pins_o.monitor = {3'b000, pins_o.pc_sw[1], idx_q, state_q};
    pins_o.leds    = 4'b0001 << idx_q;
  end

  // once started the adc stays started until it answers or the trigger drops
  a_start_held: assert property (@(posedge clk) disable iff (reset_i)
    (adc_start_o && !meas_valid_i && sa_trig_i) |=> (adc_start_o && state_q == SA_MEASURE));

endmodule

// ==== hdl/spi_reg_bank.sv ====
`include "dmm_consts.svh"

module spi_reg_bank import dmm_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   sck_i,
  input  logic                   ss_i,
  input  logic                   sdi_i,
  input  logic [3:0]             hw_flags_i,
  input  logic [`DMM_SEQ_N_W-1:0] sample_idx_last_i,
  output logic                   sdo_o,
  output reg_cfg_t               cfg_o
);

  localparam int BIT_CNT_W = $clog2(`DMM_FRAME_BITS + 1);
  localparam logic [BIT_CNT_W-1:0] FRAME = `DMM_FRAME_BITS;
  localparam logic [BIT_CNT_W-1:0] ADDR_DONE = `DMM_ADDR_W - 1;

  //////////////////////////////////////////////////////////////////////
  // pin oversampling of {ss, sck, sdi}

  logic [2:0] meta_q, sync_q;
  logic       sck_prev_q, ss_prev_q;
  logic       ss_s, sck_s, sdi_s;
  logic       sck_rise, sck_fall, ss_rise;

  assign {ss_s, sck_s, sdi_s} = sync_q;
  assign sck_rise = sck_s & ~sck_prev_q & ~ss_s;
  assign sck_fall = ~sck_s & sck_prev_q & ~ss_s;   // sdo moves here in mode 0
  assign ss_rise  = ss_s & ~ss_prev_q;             // end of frame

  logic [BIT_CNT_W-1:0]       cnt_q;
  logic                       drop_q;              // frame ran past 40 bits
  logic                       wr_q;
  logic [`DMM_FRAME_BITS-1:0] sr_q;                // address then data
  logic [`DMM_REG_W-1:0]      rd_q;                // readback shifter
  logic [`DMM_REG_W-1:0]      rd_word, status_w;
  logic [`DMM_ADDR_W-1:0]     addr_next, wr_addr;

  logic [`DMM_REG_W-1:0] regs_q [`DMM_REG_FIRST:`DMM_REG_LAST];

  assign addr_next = {sr_q[`DMM_ADDR_W-2:0], sdi_s};   // address as of the 8th edge
  assign wr_addr   = sr_q[`DMM_FRAME_BITS-1 -: `DMM_ADDR_W];
  assign sdo_o     = rd_q[`DMM_REG_W-1];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      meta_q     <= 3'b100;   // ss idles high
      sync_q     <= 3'b100;
      sck_prev_q <= 1'b0;
      ss_prev_q  <= 1'b1;
      cnt_q      <= '0;
      drop_q     <= 1'b0;
      wr_q       <= 1'b0;
      rd_q       <= '0;
    end else begin
      meta_q     <= {ss_i, sck_i, sdi_i};
      sync_q     <= meta_q;
      sck_prev_q <= sck_s;
      ss_prev_q  <= ss_s;
      wr_q       <= ss_rise && (cnt_q == FRAME) && !drop_q;   // only whole frames
      if (ss_s) begin
        cnt_q  <= '0;
        drop_q <= 1'b0;
        rd_q   <= '0;
      end else if (sck_rise) begin
        if (cnt_q == FRAME) drop_q <= 1'b1;   // long frame gets discarded
        else cnt_q <= cnt_q + 1'b1;
        if (cnt_q == ADDR_DONE) rd_q <= rd_word;   // old value from before the write
      end else if (sck_fall && cnt_q > ADDR_DONE + 1'b1) begin
        rd_q <= {rd_q[`DMM_REG_W-2:0], 1'b0};
      end
    end
  end

  // frame shifter, msb first
  always_ff @(posedge clk) begin
    if (sck_rise) sr_q <= {sr_q[`DMM_FRAME_BITS-2:0], sdi_s};
  end

  //////////////////////////////////////////////////////////////////////
  // register file

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = `DMM_REG_FIRST; i <= `DMM_REG_LAST; i++) regs_q[i] <= '0;
    end else if (wr_q && wr_addr >= `DMM_REG_FIRST && wr_addr <= `DMM_REG_LAST
                 && wr_addr != REG_STATUS) begin
      regs_q[wr_addr] <= sr_q[`DMM_REG_W-1:0];
    end
  end

  assign status_w = {8'h00,
                     1'b0, regs_q[REG_SA_SEQ_N][`DMM_SEQ_N_W-1:0], 1'b0, sample_idx_last_i,
                     regs_q[REG_SPI_MUX][3:0], hw_flags_i,
                     `DMM_STATUS_MAGIC};

  always_comb begin
    rd_word = '0;   // unmapped reads as zero
    if (addr_next == REG_STATUS) rd_word = status_w;   // live
    else if (addr_next >= `DMM_REG_FIRST && addr_next <= `DMM_REG_LAST)
      rd_word = regs_q[addr_next];
  end

  always_comb begin
    cfg_o.spi_mux      = regs_q[REG_SPI_MUX][3:0];
    cfg_o.oe_4094      = regs_q[REG_4094][0];      // 4094 outputs stay off after reset
    cfg_o.mode         = mode_e'(regs_q[REG_MODE][`DMM_MODE_W-1:0]);
    cfg_o.direct       = out_vec_t'(regs_q[REG_DIRECT][`DMM_OUT_W-1:0]);
    cfg_o.sa.seq_n     = regs_q[REG_SA_SEQ_N][`DMM_SEQ_N_W-1:0];
    cfg_o.sa.precharge = regs_q[REG_SA_PRECHARGE][`DMM_CNT_W-1:0];
    for (int i = 0; i < `DMM_SEQ_MAX; i++)
      cfg_o.sa.seq[i] = sa_entry_t'(regs_q[REG_SA_SEQ0 + i][`DMM_SEQ_W-1:0]);
    cfg_o.aperture     = regs_q[REG_ADC_APERTURE][`DMM_CNT_W-1:0];
  end

  // the count stops at a full frame and only a full count can be marked dropped
  a_frame_len: assert property (@(posedge clk) disable iff (reset_i)
    (cnt_q <= FRAME) && (!drop_q || cnt_q == FRAME));

endmodule

// ==== hdl/dmm_pkg.sv ====
`include "dmm_consts.svh"

package dmm_pkg;

  // register map, one word each
  typedef enum logic [`DMM_ADDR_W-1:0] {
    REG_SPI_MUX      = 8'd1,
    REG_4094         = 8'd2,
    REG_MODE         = 8'd3,
    REG_DIRECT       = 8'd4,
    REG_STATUS       = 8'd5,   // read only
    REG_SA_PRECHARGE = 8'd6,
    REG_SA_SEQ_N     = 8'd7,
    REG_SA_SEQ0      = 8'd8,
    REG_SA_SEQ1      = 8'd9,
    REG_SA_SEQ2      = 8'd10,
    REG_SA_SEQ3      = 8'd11,
    REG_ADC_APERTURE = 8'd12
  } reg_addr_e;

  // output function select, anything else drives zeros
  typedef enum logic [`DMM_MODE_W-1:0] {
    MODE_DIRECT  = 3'd0,
    MODE_SA_MOCK = 3'd6
  } mode_e;

  typedef enum logic [1:0] {
    SA_IDLE,
    SA_SETTLE,    // precharge wait
    SA_MEASURE    // adc running
  } sa_state_e;

  typedef struct packed {
    logic [3:0] azmux;
    logic [1:0] pc_sw;
  } sa_entry_t;

  typedef struct packed {
    logic [`DMM_SEQ_N_W-1:0]      seq_n;
    sa_entry_t [`DMM_SEQ_MAX-1:0] seq;
    logic [`DMM_CNT_W-1:0]        precharge;
  } sa_cfg_t;

  // physical pin order, msb first
  typedef struct packed {
    logic       adc_reset_n;
    logic       meas_complete;
    logic       spi_interrupt;
    logic       cmpr_latch;
    logic [3:0] adc_refmux;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } out_vec_t;

  typedef struct packed {
    logic [3:0]            spi_mux;
    logic                  oe_4094;
    mode_e                 mode;
    out_vec_t              direct;
    sa_cfg_t               sa;
    logic [`DMM_CNT_W-1:0] aperture;
  } reg_cfg_t;

endpackage

// ==== hdl/dmm_consts.svh ====
`ifndef DMM_CONSTS_SVH
`define DMM_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// spi register bank

`define DMM_REG_W         32      // every register is one word
`define DMM_ADDR_W        8
`define DMM_FRAME_BITS    40      // address byte then data word
`define DMM_REG_FIRST     1       // lowest mapped address
`define DMM_REG_LAST      12      // highest mapped address
`define DMM_STATUS_MAGIC  8'hAA   // low status byte, lets the mcu spot a dead bus

//////////////////////////////////////////////////////////////////////
// output vector and sequencer

`define DMM_OUT_W         26
`define DMM_MODE_W        3
`define DMM_SEQ_MAX       4       // entries in one sequence
`define DMM_SEQ_W         6       // azmux + pc_sw
`define DMM_SEQ_N_W       3       // holds 1 .. 4
`define DMM_IDX_W         2
`define DMM_CNT_W         24      // precharge and aperture counts, in clk

`endif
